//--- all.f
verilog/upd_periph_pkg.sv
verilog/upd_edge_sampler.sv
verilog/upd_timer.sv
verilog/upd_int_ctrl.sv
verilog/upd_sfr_bus.sv
verilog/upd7800_periph.sv
tests/upd7800_periph_assert.sv
tests/upd7800_periph_tb.sv

//--- Bender.yml
package:
  name: upd7800_periph

sources:
  # RTL, package first
  - files:
      - verilog/upd_periph_pkg.sv
      - verilog/upd_edge_sampler.sv
      - verilog/upd_timer.sv
      - verilog/upd_int_ctrl.sv
      - verilog/upd_sfr_bus.sv
      - verilog/upd7800_periph.sv

  # Testbench and bound assertions
  - target: test
    files:
      - tests/upd7800_periph_assert.sv
      - tests/upd7800_periph_tb.sv

//--- tests/upd7800_periph_tb.sv
`timescale 1ns/1ns

module upd7800_periph_tb import upd_periph_pkg::*; ();

  localparam int TICK_DIV      = 12;
  localparam int PRESCALE_BITS = 3;

  // Rough cycles per bus access including the idle edge
  localparam int BUS_OP = 4;

  // Test lengths in order with the timer at its longest reload of 511
  localparam int RUN_CYCLES = 4 + 44 * BUS_OP
                            + 6 * 8 * BUS_OP
                            + 38 * TICK_DIV + 14 * BUS_OP
                            + (511 * 8 + 9) + 12 * BUS_OP
                            + 7 * TICK_DIV + 41 + 12 * BUS_OP;
  localparam int TIMEOUT_CYCLES = 2 * RUN_CYCLES;

  logic       CLK      = 1'b0;
  logic       reset    = 1'b1;
  logic       wb_cyc   = 1'b0;
  logic       wb_stb   = 1'b0;
  logic       wb_we    = 1'b0;
  sfr_addr_e  wb_adr   = PA;
  logic [7:0] wb_dat_i = 8'h00;
  logic       int0     = 1'b0;
  logic       int1     = 1'b0;
  logic       int2     = 1'b0;
  logic       int_ack  = 1'b0;
  logic [7:0] pb_in    = 8'h00;
  logic [7:0] pc_in    = 8'h00;
  logic [7:0] wb_dat_o;
  logic       wb_ack;
  logic       int_req;
  logic [7:0] int_vector;
  logic [7:0] pa_out;
  logic [7:0] pb_out;
  logic [7:0] pb_oe;
  logic [7:0] pc_out;
  logic [7:0] pc_oe;

  int seed      = 32'h7e49;
  int cycle_cnt = 0;
  int checks    = 0;
  int data_errs = 0;
  int pend_errs = 0;
  int irq_errs  = 0;
  int uf_edges;
  logic [7:0] tm0_val;
  logic [7:0] tm1_val;

  // Register model indexed by address
  logic [7:0]           model_reg [0:7];
  logic [INT_COUNT-1:0] model_pend;
  sfr_addr_e            reg_list [6] = '{PA, MK, MB, MC, TM0, TM1};

  upd7800_periph #(
    .TICK_DIV     (TICK_DIV),
    .PRESCALE_BITS(PRESCALE_BITS)
  ) dut0 (.*);

  bind upd7800_periph upd7800_periph_assert assert0 (.*);

  always #4 CLK = ~CLK;

  always @(posedge CLK) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("Timeout: tests still running after %0d cycles", cycle_cnt);
      $display("Finished with errors");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Reference model

  function automatic logic [7:0] pb_dir();
    return ~model_reg[MB];
  endfunction

  // Bits 6..3 always drive and bit 2 never does
  function automatic logic [7:0] pc_dir();
    return (~model_reg[MC] | 8'b0111_1000) & ~8'b0000_0100;
  endfunction

  function automatic logic [7:0] expected_read(input sfr_addr_e adr);
    case (adr)
      PB:      return (pb_in & ~pb_dir()) | (model_reg[PB] & pb_dir());
      PC:      return (pc_in & ~pc_dir()) | (model_reg[PC] & pc_dir());
      IRF:     return {4'h0, model_pend};
      STM:     return 8'h00;
      default: return model_reg[adr];
    endcase
  endfunction

  // Request bit above the vector where the lowest live index wins
  function automatic logic [8:0] expected_irq();
    logic [INT_COUNT-1:0] live;
    logic [8:0]           result;
    live   = model_pend & ~model_reg[MK][INT_COUNT-1:0];
    result = '0;
    for (int i = INT_COUNT - 1; i >= 0; i--) begin
      if (live[i]) begin
        result = {1'b1, 8'h04 << i};
      end
    end
    return result;
  endfunction

  ////////////////////////////////////////
  // Compare tasks

  task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      data_errs++;
      $display("[FAIL] %0t ns: %s is %02h, expected %02h", $time, what, got, exp);
    end
  endtask

  task automatic check_pend(input sfr_addr_e adr, input logic [INT_COUNT-1:0] got,
                            input logic [INT_COUNT-1:0] exp);
    checks++;
    if (got !== exp) begin
      pend_errs++;
      $display("[FAIL] %0t ns: %s flags %b, expected %b", $time, adr.name(), got, exp);
    end
  endtask

  task automatic check_irq(input logic got_req, input logic [7:0] got_vec,
                           input logic [8:0] exp);
    checks++;
    if ({got_req, got_vec} !== exp) begin
      irq_errs++;
      $display("[FAIL] %0t ns: int_req/int_vector %b/%02h, expected %b/%02h",
               $time, got_req, got_vec, exp[8], exp[7:0]);
    end
  endtask

  // Port pins sampled before the edge updates them
  always @(posedge CLK) begin
    if (!reset) begin
      check_byte("pa_out", pa_out, model_reg[PA]);
      check_byte("pb_out", pb_out, model_reg[PB]);
      check_byte("pc_out", pc_out, model_reg[PC]);
      check_byte("pb_oe", pb_oe, pb_dir());
      check_byte("pc_oe", pc_oe, pc_dir());
    end
  end

  ////////////////////////////////////////
  // Bus and pin drivers

  task automatic bus_write(input sfr_addr_e adr, input logic [7:0] data);
    @(posedge CLK);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= 1'b1;
    wb_adr   <= adr;
    wb_dat_i <= data;
    do begin
      @(negedge CLK);
    end while (!wb_ack);
    // Write landed on the acknowledge edge
    case (adr)
      TM1:     model_reg[TM1] = data & 8'h0f;
      IRF:     model_pend = model_pend & ~data[INT_COUNT-1:0];
      STM:     ;
      default: model_reg[adr] = data;
    endcase
    @(posedge CLK);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic bus_read(input sfr_addr_e adr, output logic [7:0] data);
    @(posedge CLK);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= 1'b0;
    wb_adr <= adr;
    do begin
      @(negedge CLK);
    end while (!wb_ack);
    data = wb_dat_o;
    @(posedge CLK);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
  endtask

  task automatic read_check(input sfr_addr_e adr);
    logic [7:0] got;
    logic [7:0] exp;
    bus_read(adr, got);
    exp = expected_read(adr);
    if (adr == IRF) begin
      check_pend(adr, got[INT_COUNT-1:0], exp[INT_COUNT-1:0]);
      check_byte("IRF unused bits", got & 8'hf0, exp & 8'hf0);
    end else begin
      check_byte(adr.name(), got, exp);
    end
  endtask

  task automatic wait_ticks(input int n);
    repeat (n * TICK_DIV) @(posedge CLK);
  endtask

  // One acknowledge pulse drops the source being vectored
  task automatic pulse_ack();
    logic [INT_COUNT-1:0] live;
    @(posedge CLK);
    int_ack <= 1'b1;
    @(posedge CLK);
    int_ack <= 1'b0;
    live = model_pend & ~model_reg[MK][INT_COUNT-1:0];
    for (int i = 0; i < INT_COUNT; i++) begin
      if (live[i]) begin
        model_pend[i] = 1'b0;
        break;
      end
    end
    @(negedge CLK);
  endtask

  ////////////////////////////////////////
  // Test sequence

  initial begin
    model_reg[PA]  = 8'h00;
    model_reg[PB]  = 8'h00;
    model_reg[PC]  = 8'h00;
    model_reg[MK]  = 8'hff;
    model_reg[MB]  = 8'hff;
    model_reg[MC]  = 8'hff;
    model_reg[TM0] = 8'hff;
    model_reg[TM1] = 8'h0f;
    model_pend     = '0;
    repeat (4) @(posedge CLK);
    reset <= 1'b0;

    // Reset values then random register writes
    read_check(PA);
    read_check(MK);
    read_check(MB);
    read_check(MC);
    read_check(STM);
    repeat (3) begin
      foreach (reg_list[i]) begin
        bus_write(reg_list[i], 8'($random(seed)));
        read_check(reg_list[i]);
      end
    end

    // Port directions and pin readback
    repeat (6) begin
      @(posedge CLK);
      pb_in <= 8'($random(seed));
      pc_in <= 8'($random(seed));
      bus_write(MB, 8'($random(seed)));
      bus_write(MC, 8'($random(seed)));
      bus_write(PB, 8'($random(seed)));
      bus_write(PC, 8'($random(seed)));
      bus_write(PA, 8'($random(seed)));
      read_check(PB);
      read_check(PC);
    end

    // Let INT2 history settle after the random MK values
    bus_write(MK, 8'hff);
    wait_ticks(5);
    bus_write(IRF, 8'h0f);
    read_check(IRF);

    // INT1 rising edge
    @(posedge CLK);
    int1 <= 1'b0;
    wait_ticks(2);
    int1 <= 1'b1;
    wait_ticks(5);
    model_pend[INT1] = 1'b1;
    read_check(IRF);
    bus_write(MK, 8'hfb);
    @(negedge CLK);
    check_irq(int_req, int_vector, expected_irq());
    bus_write(MK, 8'hff);
    @(negedge CLK);
    check_irq(int_req, int_vector, expected_irq());
    read_check(IRF);

    // With INT2 inverted only the falling edge counts
    bus_write(MK, 8'hd7);
    wait_ticks(6);
    bus_write(IRF, 8'h0f);
    read_check(IRF);
    @(posedge CLK);
    int2 <= 1'b1;
    wait_ticks(5);
    read_check(IRF);
    int2 <= 1'b0;
    wait_ticks(5);
    model_pend[INT2] = 1'b1;
    read_check(IRF);
    @(negedge CLK);
    check_irq(int_req, int_vector, expected_irq());
    bus_write(MK, 8'hff);
    bus_write(IRF, 8'h0f);

    // Timer underflow after a start command
    bus_write(MK, 8'hfd);
    tm0_val = 8'($random(seed));
    tm1_val = 8'($random(seed)) & 8'h01;
    bus_write(TM0, tm0_val);
    bus_write(TM1, tm1_val);
    read_check(TM0);
    read_check(TM1);
    uf_edges = int'({tm1_val[3:0], tm0_val}) * 8 + 9;
    bus_write(STM, 8'h00);
    repeat (uf_edges - 2) @(posedge CLK);
    @(negedge CLK);
    check_irq(int_req, int_vector, expected_irq());
    @(negedge CLK);
    model_pend[INTT] = 1'b1;
    check_irq(int_req, int_vector, expected_irq());
    // Longest reload keeps the timer quiet from here on
    bus_write(TM0, 8'hff);
    bus_write(TM1, 8'h0f);
    bus_write(STM, 8'h00);
    bus_write(IRF, 8'h02);
    @(negedge CLK);
    check_irq(int_req, int_vector, expected_irq());

    // Priority with INT0, INTT and INT1 together
    bus_write(MK, 8'hf0);
    @(posedge CLK);
    int1 <= 1'b0;
    wait_ticks(2);
    int1 <= 1'b1;
    wait_ticks(5);
    model_pend[INT1] = 1'b1;
    bus_write(TM0, 8'h03);
    bus_write(TM1, 8'h00);
    bus_write(STM, 8'h00);
    repeat (40) @(posedge CLK);
    bus_write(TM0, 8'hff);
    bus_write(TM1, 8'h0f);
    bus_write(STM, 8'h00);
    model_pend[INTT] = 1'b1;
    read_check(IRF);
    @(posedge CLK);
    int0 <= 1'b1;
    @(posedge CLK);
    @(negedge CLK);
    model_pend[INT0] = 1'b1;
    check_irq(int_req, int_vector, expected_irq());
    @(posedge CLK);
    int0 <= 1'b0;
    @(posedge CLK);
    @(negedge CLK);
    model_pend[INT0] = 1'b0;
    check_irq(int_req, int_vector, expected_irq());
    pulse_ack();
    check_irq(int_req, int_vector, expected_irq());
    pulse_ack();
    check_irq(int_req, int_vector, expected_irq());
    read_check(IRF);

    repeat (2) @(posedge CLK);
    $display("Checks %0d, data errors %0d, pending errors %0d, irq errors %0d, assertions %0d",
             checks, data_errs, pend_errs, irq_errs, dut0.assert0.fail_cnt);
    if (data_errs + pend_errs + irq_errs + dut0.assert0.fail_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- tests/upd7800_periph_assert.sv
`timescale 1ns/1ns

module upd7800_periph_assert (
  input logic       CLK,
  input logic       reset,
  input logic       wb_stb,
  input logic       wb_ack,
  input logic       int_req,
  input logic [7:0] int_vector,
  input logic [7:0] pc_oe
);

  int fail_cnt = 0;

  ////////////////////////////////////////
  // Bus handshake

  ack_needs_stb: assert property (@(posedge CLK) disable iff (reset) wb_ack |-> wb_stb)
    else begin
      $error("wb_ack high without wb_stb");
      fail_cnt++;
    end

  ack_one_cycle: assert property (@(posedge CLK) disable iff (reset) wb_ack |=> !wb_ack)
    else begin
      $error("wb_ack held for two cycles");
      fail_cnt++;
    end

  ////////////////////////////////////////
  // Interrupts and fixed port bits

  vector_in_table: assert property (@(posedge CLK) disable iff (reset)
    int_req |-> (int_vector inside {8'h04, 8'h08, 8'h10, 8'h20}))
    else begin
      $error("int_vector %02h not in the vector table", int_vector);
      fail_cnt++;
    end

  // Port C bits 6..3 never turn around
  pc_fixed_out: assert property (@(posedge CLK) disable iff (reset) pc_oe[6:3] == 4'hf)
    else begin
      $error("port C fixed output bits not driving");
      fail_cnt++;
    end

endmodule

//--- verilog/upd7800_periph.sv
`timescale 1ns/1ns

module upd7800_periph import upd_periph_pkg::*; #(
  parameter int TICK_DIV      = 12,
  parameter int PRESCALE_BITS = 3
) (
  input  logic       CLK,
  input  logic       reset,
  input  logic       wb_cyc,
  input  logic       wb_stb,
  input  logic       wb_we,
  input  sfr_addr_e  wb_adr,
  input  logic [7:0] wb_dat_i,
  output logic [7:0] wb_dat_o,
  output logic       wb_ack,
  input  logic       int0,
  input  logic       int1,
  input  logic       int2,
  input  logic       int_ack,
  output logic       int_req,
  output logic [7:0] int_vector,
  input  logic [7:0] pb_in,
  input  logic [7:0] pc_in,
  output logic [7:0] pa_out,
  output logic [7:0] pb_out,
  output logic [7:0] pb_oe,
  output logic [7:0] pc_out,
  output logic [7:0] pc_oe
);

  logic [7:0]           mk;
  logic                 int2_pol;
  logic [TM_WIDTH-1:0]  tm_reload;
  logic                 stm_pulse;
  logic [INT_COUNT-1:0] irf_clr;
  logic [INT_COUNT-1:0] int_pend;
  logic                 int1_set;
  logic                 int2_set;
  logic                 tmr_uf;

  upd_sfr_bus sfr_bus0 (
    .CLK      (CLK),
    .reset    (reset),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack   (wb_ack),
    .pb_in    (pb_in),
    .pc_in    (pc_in),
    .pa_out   (pa_out),
    .pb_out   (pb_out),
    .pb_oe    (pb_oe),
    .pc_out   (pc_out),
    .pc_oe    (pc_oe),
    .mk       (mk),
    .int2_pol (int2_pol),
    .tm_reload(tm_reload),
    .stm_pulse(stm_pulse),
    .irf_clr  (irf_clr),
    .int_pend (int_pend)
  );

  upd_edge_sampler #(
    .TICK_DIV(TICK_DIV)
  ) edge_sampler0 (
    .CLK     (CLK),
    .reset   (reset),
    .int1    (int1),
    .int2    (int2),
    .int2_pol(int2_pol),
    .int1_set(int1_set),
    .int2_set(int2_set)
  );

  upd_timer #(
    .PRESCALE_BITS(PRESCALE_BITS)
  ) timer0 (
    .CLK      (CLK),
    .reset    (reset),
    .tm_reload(tm_reload),
    .stm_pulse(stm_pulse),
    .tmr_uf   (tmr_uf)
  );

  upd_int_ctrl int_ctrl0 (
    .CLK       (CLK),
    .reset     (reset),
    .int0      (int0),
    .int1_set  (int1_set),
    .int2_set  (int2_set),
    .tmr_uf    (tmr_uf),
    .mk        (mk),
    .int_ack   (int_ack),
    .irf_clr   (irf_clr),
    .int_pend  (int_pend),
    .int_req   (int_req),
    .int_vector(int_vector)
  );

endmodule

//--- verilog/upd_sfr_bus.sv
`timescale 1ns/1ns

module upd_sfr_bus import upd_periph_pkg::*; (
  input  logic                 CLK,
  input  logic                 reset,
  // Wishbone slave
  input  logic                 wb_cyc,
  input  logic                 wb_stb,
  input  logic                 wb_we,
  input  sfr_addr_e            wb_adr,
  input  logic [7:0]           wb_dat_i,
  output logic [7:0]           wb_dat_o,
  output logic                 wb_ack,
  // Port pins
  input  logic [7:0]           pb_in,
  input  logic [7:0]           pc_in,
  output logic [7:0]           pa_out,
  output logic [7:0]           pb_out,
  output logic [7:0]           pb_oe,
  output logic [7:0]           pc_out,
  output logic [7:0]           pc_oe,
  // To the interrupt and timer blocks
  output logic [7:0]           mk,
  output logic                 int2_pol,
  output logic [TM_WIDTH-1:0]  tm_reload,
  output logic                 stm_pulse,
  output logic [INT_COUNT-1:0] irf_clr,
  input  logic [INT_COUNT-1:0] int_pend
);

  logic                wb_go;
  logic                wr_go;
  logic [7:0]          pa_q;
  logic [7:0]          pb_q;
  logic [7:0]          pc_q;
  logic [7:0]          mb_q;
  logic [7:0]          mc_q;
  logic [7:0]          tm0_q;
  logic [TM_WIDTH-9:0] tm1_q;
  logic [7:0]          pb_rd;
  logic [7:0]          pc_rd;

  ////////////////////////////////////////
  // Bus handshake

  // Single cycle acknowledge, no wait states
  assign wb_go = wb_cyc & wb_stb & ~wb_ack;
  assign wr_go = wb_go & wb_we;

  always_ff @(posedge CLK) begin
    if (reset) begin
      wb_ack    <= 1'b0;
      stm_pulse <= 1'b0;
      irf_clr   <= '0;
    end else begin
      wb_ack    <= wb_go;
      stm_pulse <= wr_go && (wb_adr == STM);
      irf_clr   <= (wr_go && (wb_adr == IRF)) ? wb_dat_i[INT_COUNT-1:0] : '0;
    end
  end

  ////////////////////////////////////////
  // Special registers

  always_ff @(posedge CLK) begin
    if (reset) begin
      pa_q  <= '0;
      pb_q  <= '0;
      pc_q  <= '0;
      mk    <= MK_RESET;
      mb_q  <= MB_RESET;
      mc_q  <= MC_RESET;
      tm0_q <= '1;
      tm1_q <= '1;
    end else if (wr_go) begin
      case (wb_adr)
        PA:      pa_q  <= wb_dat_i;
        PB:      pb_q  <= wb_dat_i;
        PC:      pc_q  <= wb_dat_i;
        MK:      mk    <= wb_dat_i;
        MB:      mb_q  <= wb_dat_i;
        MC:      mc_q  <= wb_dat_i;
        TM0:     tm0_q <= wb_dat_i;
        TM1:     tm1_q <= wb_dat_i[TM_WIDTH-9:0];
        default: ;
      endcase
    end
  end

  assign int2_pol  = mk[MK_INT2_POL_BIT];
  assign tm_reload = {tm1_q, tm0_q};

  ////////////////////////////////////////
  // Port direction

  // Mode bit set makes the pin an input
  assign pb_oe = ~mb_q;
  assign pc_oe = (~mc_q | PC_FIXED_OUT) & ~PC_FIXED_IN;

  assign pa_out = pa_q;
  assign pb_out = pb_q;
  assign pc_out = pc_q;

  // Input bits read the pin, output bits read the latch
  assign pb_rd = (pb_in & ~pb_oe) | (pb_q & pb_oe);
  assign pc_rd = (pc_in & ~pc_oe) | (pc_q & pc_oe);

  ////////////////////////////////////////
  // Readback

  // Host holds the address until it sees wb_ack
  always_comb begin
    case (wb_adr)
      PA:      wb_dat_o = pa_q;
      PB:      wb_dat_o = pb_rd;
      PC:      wb_dat_o = pc_rd;
      MK:      wb_dat_o = mk;
      MB:      wb_dat_o = mb_q;
      MC:      wb_dat_o = mc_q;
      TM0:     wb_dat_o = tm0_q;
      TM1:     wb_dat_o = {{(16 - TM_WIDTH){1'b0}}, tm1_q};
      IRF:     wb_dat_o = {{(8 - INT_COUNT){1'b0}}, int_pend};
      default: wb_dat_o = 8'h00;
    endcase
  end

endmodule

//--- verilog/upd_int_ctrl.sv
`timescale 1ns/1ns

module upd_int_ctrl import upd_periph_pkg::*; (
  input  logic                 CLK,
  input  logic                 reset,
  input  logic                 int0,
  input  logic                 int1_set,
  input  logic                 int2_set,
  input  logic                 tmr_uf,
  input  logic [7:0]           mk,
  input  logic                 int_ack,
  input  logic [INT_COUNT-1:0] irf_clr,
  output logic [INT_COUNT-1:0] int_pend,
  output logic                 int_req,
  output logic [7:0]           int_vector
);

  logic [INT_COUNT-1:0] pend_set;
  logic [INT_COUNT-1:0] pend_clr;
  logic [INT_COUNT-1:0] pend_en;
  logic [INT_COUNT-1:0] ack_mask;
  int_idx_e             sel;

  ////////////////////////////////////////
  // Set and clear sources

  always_comb begin
    pend_set       = '0;
    pend_set[INT0] = int0;
    pend_set[INTT] = tmr_uf;
    pend_set[INT1] = int1_set;
    pend_set[INT2] = int2_set;
  end

  // Acknowledge drops only the source being vectored
  always_comb begin
    ack_mask = '0;
    if (int_ack && int_req) begin
      ack_mask[sel] = 1'b1;
    end
  end

  always_comb begin
    pend_clr       = irf_clr | ack_mask;
    // INT0 is level sensitive and follows the pin
    pend_clr[INT0] = pend_clr[INT0] | ~int0;
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      int_pend <= '0;
    end else begin
      // A new set beats a clear on the same edge
      int_pend <= (int_pend & ~pend_clr) | pend_set;
    end
  end

  ////////////////////////////////////////
  // Masking and priority

  // MK bit set means the source is masked
  assign pend_en = int_pend & ~mk[INT_COUNT-1:0];
  assign int_req = |pend_en;

  always_comb begin
    sel = INT0;
    for (int i = INT_COUNT - 1; i >= 0; i--) begin
      if (pend_en[i]) begin
        sel = int_idx_e'(i);
      end
    end
  end

  assign int_vector = int_req ? INT_VECTOR[sel] : 8'h00;

endmodule

//--- verilog/upd_timer.sv
`timescale 1ns/1ns

module upd_timer import upd_periph_pkg::*; #(
  parameter int PRESCALE_BITS = 3
) (
  input  logic                CLK,
  input  logic                reset,
  input  logic [TM_WIDTH-1:0] tm_reload,
  input  logic                stm_pulse,
  output logic                tmr_uf
);

  localparam int CNT_W = TM_WIDTH + PRESCALE_BITS;

  // Upper bits count, lower bits are the prescaler
  logic [CNT_W-1:0] cnt;

  assign tmr_uf = (cnt == '0);

  ////////////////////////////////////////
  // Down counter

  always_ff @(posedge CLK) begin
    if (reset) begin
      cnt <= '1;
    end else if (tmr_uf || stm_pulse) begin
      // Restart prescaler with the reload value on top
      cnt <= {tm_reload, {PRESCALE_BITS{1'b1}}};
    end else begin
      cnt <= cnt - 1'b1;
    end
  end

  // Period works out to (tm_reload + 1) << PRESCALE_BITS

endmodule

//--- verilog/upd_edge_sampler.sv
`timescale 1ns/1ns

module upd_edge_sampler #(
  parameter int TICK_DIV = 12
) (
  input  logic CLK,
  input  logic reset,
  input  logic int1,
  input  logic int2,
  input  logic int2_pol,
  output logic int1_set,
  output logic int2_set
);

  localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

  logic [CNT_W-1:0] tick_cnt;
  logic             tick;
  logic             int2_smp;
  logic [3:0]       hist1;
  logic [3:0]       hist2;

  ////////////////////////////////////////
  // Sample tick, one every TICK_DIV clocks

  assign tick = (tick_cnt == CNT_W'(TICK_DIV - 1));

  always_ff @(posedge CLK) begin
    if (reset) begin
      tick_cnt <= '0;
    end else if (tick) begin
      tick_cnt <= '0;
    end else begin
      tick_cnt <= tick_cnt + 1'b1;
    end
  end

  ////////////////////////////////////////
  // Sample histories, newest in bit 0

  // Low polarity means INT2 is active low
  assign int2_smp = int2 ^ ~int2_pol;

  always_ff @(posedge CLK) begin
    if (reset) begin
      hist1 <= '0;
      hist2 <= '0;
    end else if (tick) begin
      hist1 <= {hist1[2:0], int1};
      hist2 <= {hist2[2:0], int2_smp};
    end
  end

  // One low sample followed by three highs counts as an edge
  assign int1_set = tick & (hist1 == 4'b0111);
  assign int2_set = tick & (hist2 == 4'b0111);

endmodule

//--- verilog/upd_periph_pkg.sv
package upd_periph_pkg;

  ////////////////////////////////////////
  // Register map

  typedef enum logic [3:0] {
    PA  = 4'd0,
    PB  = 4'd1,
    PC  = 4'd2,
    MK  = 4'd3,
    MB  = 4'd4,
    MC  = 4'd5,
    TM0 = 4'd6,
    TM1 = 4'd7,
    // Write-only timer start
    STM = 4'd8,
    // Pending interrupt flags, write one to clear
    IRF = 4'd9
  } sfr_addr_e;

  ////////////////////////////////////////
  // Interrupt sources

  // Bit position doubles as priority, lowest wins
  typedef enum logic [1:0] {
    INT0 = 2'd0,
    INTT = 2'd1,
    INT1 = 2'd2,
    INT2 = 2'd3
  } int_idx_e;

  localparam int INT_COUNT = 4;

  // Entry i is the vector for source i
  localparam logic [INT_COUNT-1:0][7:0] INT_VECTOR = {8'h20, 8'h10, 8'h08, 8'h04};

  ////////////////////////////////////////
  // Reset values and fixed bits

  localparam logic [7:0] MK_RESET = 8'hff;
  localparam logic [7:0] MB_RESET = 8'hff;
  localparam logic [7:0] MC_RESET = 8'hff;

  // INT2 is taken inverted while this MK bit is low
  localparam int MK_INT2_POL_BIT = 5;

  // Port C bits 6..3 always drive, bit 2 always listens
  localparam logic [7:0] PC_FIXED_OUT = 8'b0111_1000;
  localparam logic [7:0] PC_FIXED_IN  = 8'b0000_0100;

  localparam int TM_WIDTH = 12;

endpackage
